// File: Bender.yml
package:
  name: fpu_unit

sources:
  - hdl/fpu_pkg.sv
  - hdl/operand_forward.sv
  - hdl/op_decode.sv
  - hdl/lane_exec.sv
  - hdl/result_drive.sv
  - hdl/fpu_unit_top.sv
  - target: test
    files:
      - test/tb_fpu_unit.sv

// File: build.f
hdl/fpu_pkg.sv
hdl/operand_forward.sv
hdl/op_decode.sv
hdl/lane_exec.sv
hdl/result_drive.sv
hdl/fpu_unit_top.sv
test/tb_fpu_unit.sv

// File: hdl/fpu_pkg.sv
// fpu operand shell definitions
package fpu_pkg;

  // operand and bus word widths
  localparam int OPND_W = 68;
  localparam int WORD_W = OPND_W + 1;

  typedef logic [OPND_W-1:0] opnd_t;

  // top bit carries even parity over the data bits
  typedef logic [WORD_W-1:0] bus_word_t;

  // raw word or tag plus two single-precision lanes
  typedef union packed {
    opnd_t raw;
    struct packed {
      logic [3:0]  tag;
      logic [31:0] hi;
      logic [31:0] lo;
    } lane;
  } opnd_u;

  typedef logic [7:0] opcode_t;

  // logic family, low two bits pick the function
  localparam opcode_t OP_LOGIC  = 8'h10;
  localparam opcode_t OP_SWAP   = 8'h20;
  localparam opcode_t OP_DUP_LO = 8'h21;
  localparam opcode_t OP_DUP_HI = 8'h22;
  localparam opcode_t OP_COPY_A = 8'h30;

  typedef enum logic [2:0] {
    FN_AND    = 3'd0,
    FN_OR     = 3'd1,
    FN_XOR    = 3'd2,
    FN_ANDN   = 3'd3,
    FN_SWAP   = 3'd4,
    FN_DUP_LO = 3'd5,
    FN_DUP_HI = 3'd6,
    FN_COPY_A = 3'd7
  } func_e;

  // exception return word
  localparam int RET_W         = 14;
  localparam int CAUSE_PARITY  = 0;
  localparam int CAUSE_ILLEGAL = 1;

endpackage

// File: hdl/fpu_unit_top.sv
// fpu operand shell top
module fpu_unit_top #(
  parameter int NUM_BUS = 4
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 en,
  input  fpu_pkg::opcode_t                     op,
  input  fpu_pkg::bus_word_t                   opnd_a,
  input  fpu_pkg::bus_word_t                   opnd_b,
  input  fpu_pkg::bus_word_t [NUM_BUS-1:0]     bus_data,
  input  logic [NUM_BUS-1:0]                   fwd_now_a,
  input  logic [NUM_BUS-1:0]                   fwd_prev_a,
  input  logic [NUM_BUS-1:0]                   fwd_now_b,
  input  logic [NUM_BUS-1:0]                   fwd_prev_b,
  output logic                                 res_valid,
  output fpu_pkg::bus_word_t                   res_word,
  output logic                                 ret_en,
  output logic [fpu_pkg::RET_W-1:0]            ret_code
);
  import fpu_pkg::*;

  opnd_t opnd_a_q;
  opnd_t opnd_b_q;
  logic  par_err_q;
  logic  fwd_valid;
  func_e func_q;
  logic  illegal_q;
  opnd_t exec_data;
  logic  exec_err;
  logic  exec_illegal;
  logic  exec_valid;

  // input side
  operand_forward #(
    .NUM_BUS (NUM_BUS)
  ) u_fwd (
    .clk        (clk),
    .rst        (rst),
    .en         (en),
    .opnd_a     (opnd_a),
    .opnd_b     (opnd_b),
    .bus_data   (bus_data),
    .fwd_now_a  (fwd_now_a),
    .fwd_prev_a (fwd_prev_a),
    .fwd_now_b  (fwd_now_b),
    .fwd_prev_b (fwd_prev_b),
    .opnd_a_q   (opnd_a_q),
    .opnd_b_q   (opnd_b_q),
    .par_err_q  (par_err_q),
    .fwd_valid  (fwd_valid)
  );

  op_decode u_dec (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .op        (op),
    .func_q    (func_q),
    .illegal_q (illegal_q)
  );

  lane_exec u_exec (
    .clk          (clk),
    .rst          (rst),
    .fwd_valid    (fwd_valid),
    .opnd_a_q     (opnd_a_q),
    .opnd_b_q     (opnd_b_q),
    .par_err_q    (par_err_q),
    .func_q       (func_q),
    .illegal_q    (illegal_q),
    .exec_data    (exec_data),
    .exec_err     (exec_err),
    .exec_illegal (exec_illegal),
    .exec_valid   (exec_valid)
  );

  // output side
  result_drive u_out (
    .clk          (clk),
    .rst          (rst),
    .exec_data    (exec_data),
    .exec_err     (exec_err),
    .exec_illegal (exec_illegal),
    .exec_valid   (exec_valid),
    .res_valid    (res_valid),
    .res_word     (res_word),
    .ret_en       (ret_en),
    .ret_code     (ret_code)
  );

endmodule

// File: hdl/lane_exec.sv
// logic and lane permute stage
module lane_exec (
  input  logic           clk,
  input  logic           rst,
  input  logic           fwd_valid,
  input  fpu_pkg::opnd_t opnd_a_q,
  input  fpu_pkg::opnd_t opnd_b_q,
  input  logic           par_err_q,
  input  fpu_pkg::func_e func_q,
  input  logic           illegal_q,
  output fpu_pkg::opnd_t exec_data,
  output logic           exec_err,
  output logic           exec_illegal,
  output logic           exec_valid
);
  import fpu_pkg::*;

  opnd_u a_u;
  opnd_u b_u;
  opnd_u res_u;

  assign a_u.raw = opnd_a_q;
  assign b_u.raw = opnd_b_q;

  always_comb begin
    // permutes start from A so its tag rides along
    res_u = a_u;
    case (func_q)
      FN_AND:    res_u.raw = a_u.raw & b_u.raw;
      FN_OR:     res_u.raw = a_u.raw | b_u.raw;
      FN_XOR:    res_u.raw = a_u.raw ^ b_u.raw;
      FN_ANDN:   res_u.raw = a_u.raw & ~b_u.raw;
      FN_SWAP: begin
        res_u.lane.hi = a_u.lane.lo;
        res_u.lane.lo = a_u.lane.hi;
      end
      FN_DUP_LO: res_u.lane.hi = a_u.lane.lo;
      FN_DUP_HI: res_u.lane.lo = a_u.lane.hi;
      default:   res_u = a_u;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fwd_valid) begin
      exec_data <= res_u.raw;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exec_valid   <= 1'b0;
      exec_err     <= 1'b0;
      exec_illegal <= 1'b0;
    end else begin
      exec_valid   <= fwd_valid;
      exec_err     <= fwd_valid & par_err_q;
      exec_illegal <= fwd_valid & illegal_q;
    end
  end

endmodule

// File: hdl/op_decode.sv
// opcode decode
module op_decode (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  fpu_pkg::opcode_t op,
  output fpu_pkg::func_e   func_q,
  output logic             illegal_q
);
  import fpu_pkg::*;

  func_e func_d;
  logic  illegal_d;

  always_comb begin
    func_d    = FN_COPY_A;
    illegal_d = 1'b0;
    if (op[7:2] == OP_LOGIC[7:2]) begin
      // and, or, xor, and-not in encoding order
      func_d = func_e'({1'b0, op[1:0]});
    end else begin
      case (op)
        OP_SWAP: begin
          func_d = FN_SWAP;
        end
        OP_DUP_LO: begin
          func_d = FN_DUP_LO;
        end
        OP_DUP_HI: begin
          func_d = FN_DUP_HI;
        end
        OP_COPY_A: begin
          func_d = FN_COPY_A;
        end
        default: begin
          illegal_d = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      func_q    <= FN_AND;
      illegal_q <= 1'b0;
    end else if (en) begin
      func_q    <= func_d;
      illegal_q <= illegal_d;
    end
  end

endmodule

// File: hdl/operand_forward.sv
// operand forwarding and parity check
module operand_forward #(
  parameter int NUM_BUS = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             en,
  input  fpu_pkg::bus_word_t               opnd_a,
  input  fpu_pkg::bus_word_t               opnd_b,
  input  fpu_pkg::bus_word_t [NUM_BUS-1:0] bus_data,
  input  logic [NUM_BUS-1:0]               fwd_now_a,
  input  logic [NUM_BUS-1:0]               fwd_prev_a,
  input  logic [NUM_BUS-1:0]               fwd_now_b,
  input  logic [NUM_BUS-1:0]               fwd_prev_b,
  output fpu_pkg::opnd_t                   opnd_a_q,
  output fpu_pkg::opnd_t                   opnd_b_q,
  output logic                             par_err_q,
  output logic                             fwd_valid
);
  import fpu_pkg::*;

  bus_word_t [NUM_BUS-1:0] bus_prev;
  bus_word_t               sel_a;
  bus_word_t               sel_b;

  // current bus wins over previous bus, port value last
  function automatic bus_word_t pick_source(
    input bus_word_t               port_word,
    input logic [NUM_BUS-1:0]      sel_now,
    input logic [NUM_BUS-1:0]      sel_prev,
    input bus_word_t [NUM_BUS-1:0] cur,
    input bus_word_t [NUM_BUS-1:0] old
  );
    bus_word_t now_or;
    bus_word_t prev_or;
    now_or  = '0;
    prev_or = '0;
    for (int i = 0; i < NUM_BUS; i++) begin
      if (sel_now[i]) begin
        now_or = now_or | cur[i];
      end
      if (sel_prev[i]) begin
        prev_or = prev_or | old[i];
      end
    end
    if (|sel_now) begin
      return now_or;
    end else if (|sel_prev) begin
      return prev_or;
    end
    return port_word;
  endfunction

  // bus history, taken on every edge
  always_ff @(posedge clk) begin
    bus_prev <= bus_data;
  end

  always_comb begin
    sel_a = pick_source(opnd_a, fwd_now_a, fwd_prev_a, bus_data, bus_prev);
    sel_b = pick_source(opnd_b, fwd_now_b, fwd_prev_b, bus_data, bus_prev);
  end

  always_ff @(posedge clk) begin
    if (en) begin
      opnd_a_q <= sel_a[OPND_W-1:0];
      opnd_b_q <= sel_b[OPND_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      par_err_q <= 1'b0;
      fwd_valid <= 1'b0;
    end else begin
      fwd_valid <= en;
      // odd count of ones over all 69 bits
      if (en) begin
        par_err_q <= (^sel_a) | (^sel_b);
      end
    end
  end

endmodule

// File: hdl/result_drive.sv
// result bus and exception return
module result_drive (
  input  logic                      clk,
  input  logic                      rst,
  input  fpu_pkg::opnd_t            exec_data,
  input  logic                      exec_err,
  input  logic                      exec_illegal,
  input  logic                      exec_valid,
  output logic                      res_valid,
  output fpu_pkg::bus_word_t        res_word,
  output logic                      ret_en,
  output logic [fpu_pkg::RET_W-1:0] ret_code
);
  import fpu_pkg::*;

  logic             fault;
  opnd_t            data_d;
  bus_word_t        word_d;
  logic [RET_W-1:0] cause_d;

  always_comb begin
    fault = exec_err | exec_illegal;
    // faulted results go out as zero data
    data_d = fault ? '0 : exec_data;
    word_d = exec_valid ? {^data_d, data_d} : '0;
    cause_d = '0;
    cause_d[CAUSE_PARITY]  = exec_valid & exec_err;
    cause_d[CAUSE_ILLEGAL] = exec_valid & exec_illegal;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      res_word  <= '0;
      ret_en    <= 1'b0;
      ret_code  <= '0;
    end else begin
      res_valid <= exec_valid;
      res_word  <= word_d;
      ret_en    <= |cause_d;
      ret_code  <= cause_d;
    end
  end

endmodule

// File: test/tb_fpu_unit.sv
// fpu unit testbench
module tb_fpu_unit;
  import fpu_pkg::*;

  localparam int NUM_BUS = 4;
  localparam int WAIT_LIMIT = 100;

  logic clk;
  logic rst;
  logic en;
  opcode_t op;
  bus_word_t opnd_a;
  bus_word_t opnd_b;
  bus_word_t [NUM_BUS-1:0] bus_data;
  logic [NUM_BUS-1:0] fwd_now_a;
  logic [NUM_BUS-1:0] fwd_prev_a;
  logic [NUM_BUS-1:0] fwd_now_b;
  logic [NUM_BUS-1:0] fwd_prev_b;
  logic res_valid;
  bus_word_t res_word;
  logic ret_en;
  logic [RET_W-1:0] ret_code;

  int seed;
  int cycle;
  bus_word_t [NUM_BUS-1:0] last_bus;
  int exp_edge[$];
  bus_word_t exp_word[$];
  logic [RET_W-1:0] exp_ret[$];

  fpu_unit_top #(.NUM_BUS(NUM_BUS)) u_dut (
    .clk(clk), .rst(rst), .en(en), .op(op), .opnd_a(opnd_a), .opnd_b(opnd_b),
    .bus_data(bus_data), .fwd_now_a(fwd_now_a), .fwd_prev_a(fwd_prev_a),
    .fwd_now_b(fwd_now_b), .fwd_prev_b(fwd_prev_b), .res_valid(res_valid),
    .res_word(res_word), .ret_en(ret_en), .ret_code(ret_code)
  );

  always #10 clk = ~clk;

  function automatic logic chance(input int pct);
    logic [31:0] r;
    r = $random(seed);
    return (r % 100) < pct;
  endfunction

  // random data with even parity unless flip is set
  function automatic bus_word_t make_word(input logic flip);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    opnd_t d;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    d = {r2[3:0], r1, r0};
    return {(^d) ^ flip, d};
  endfunction

  // mostly one-hot, sometimes empty, rarely two buses
  function automatic logic [NUM_BUS-1:0] make_sel();
    logic [31:0] r;
    logic [NUM_BUS-1:0] sel;
    r = $random(seed);
    if (r[0]) return '0;
    sel = 1 << (r[15:8] % NUM_BUS);
    if (r[7:4] == 4'd0) sel = sel | (1 << (r[23:16] % NUM_BUS));
    return sel;
  endfunction

  function automatic opcode_t pick_op(input int kind);
    logic [31:0] r;
    r = $random(seed);
    if (kind == 0) return OP_LOGIC | opcode_t'(r[1:0]);
    if (kind == 1) begin
      if (r[1:0] == 2'd0) return OP_SWAP;
      if (r[1:0] == 2'd1) return OP_DUP_LO;
      if (r[1:0] == 2'd2) return OP_DUP_HI;
      return OP_COPY_A;
    end
    if (kind == 2) return r[2] ? pick_op(0) : pick_op(1);
    return r[3] ? opcode_t'(r[15:8]) : pick_op(2);
  endfunction

  // now-select first, then prev-select, then the port
  function automatic bus_word_t source_word(input bus_word_t port,
      input logic [NUM_BUS-1:0] now, input logic [NUM_BUS-1:0] prev,
      input bus_word_t [NUM_BUS-1:0] cur, input bus_word_t [NUM_BUS-1:0] old);
    bus_word_t w;
    w = '0;
    if (now == '0 && prev == '0) return port;
    for (int i = 0; i < NUM_BUS; i++) begin
      if (now != '0 && now[i]) w = w | cur[i];
      else if (now == '0 && prev[i]) w = w | old[i];
    end
    return w;
  endfunction

  // returns the illegal flag
  function automatic logic decode_model(input opcode_t opc, output func_e f);
    f = FN_COPY_A;
    case (opc)
      8'h10: f = FN_AND;
      8'h11: f = FN_OR;
      8'h12: f = FN_XOR;
      8'h13: f = FN_ANDN;
      8'h20: f = FN_SWAP;
      8'h21: f = FN_DUP_LO;
      8'h22: f = FN_DUP_HI;
      8'h30: f = FN_COPY_A;
      default: return 1'b1;
    endcase
    return 1'b0;
  endfunction

  function automatic opnd_t exec_model(input func_e f, input opnd_t a, input opnd_t b);
    case (f)
      FN_AND: return a & b;
      FN_OR: return a | b;
      FN_XOR: return a ^ b;
      FN_ANDN: return a & ~b;
      FN_SWAP: return {a[67:64], a[31:0], a[63:32]};
      FN_DUP_LO: return {a[67:64], a[31:0], a[31:0]};
      FN_DUP_HI: return {a[67:64], a[63:32], a[63:32]};
      default: return a;
    endcase
  endfunction

  task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_ret(input string name, input logic [RET_W-1:0] exp,
      input logic [RET_W-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1, "return code mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("** FAIL **");
    $fatal(1, "timeout");
  endtask

  // one clock of stimulus, expected result lands three counts later
  task automatic step(input logic do_en, input opcode_t opc, input logic use_fwd,
      input int bad_pct);
    bus_word_t [NUM_BUS-1:0] cur;
    bus_word_t a_port;
    bus_word_t b_port;
    bus_word_t a_src;
    bus_word_t b_src;
    logic [NUM_BUS-1:0] sel [4];
    func_e f;
    logic ill;
    logic perr;
    opnd_t data;
    logic [RET_W-1:0] ret;
    @(posedge clk);
    cycle++;
    for (int i = 0; i < NUM_BUS; i++) cur[i] = make_word(chance(bad_pct));
    a_port = make_word(chance(bad_pct));
    b_port = make_word(chance(bad_pct));
    for (int i = 0; i < 4; i++) sel[i] = use_fwd ? make_sel() : '0;
    if (do_en) begin
      a_src = source_word(a_port, sel[0], sel[1], cur, last_bus);
      b_src = source_word(b_port, sel[2], sel[3], cur, last_bus);
      ill = decode_model(opc, f);
      perr = (^a_src) | (^b_src);
      data = (ill || perr) ? '0 : exec_model(f, a_src[OPND_W-1:0], b_src[OPND_W-1:0]);
      ret = '0;
      ret[CAUSE_PARITY] = perr;
      ret[CAUSE_ILLEGAL] = ill;
      exp_edge.push_back(cycle + 3);
      exp_word.push_back({^data, data});
      exp_ret.push_back(ret);
    end
    en <= do_en;
    op <= opc;
    opnd_a <= a_port;
    opnd_b <= b_port;
    bus_data <= cur;
    fwd_now_a <= sel[0];
    fwd_prev_a <= sel[1];
    fwd_now_b <= sel[2];
    fwd_prev_b <= sel[3];
    last_bus = cur;
  endtask

  task automatic run_phase(input int n, input int en_pct, input int kind,
      input logic use_fwd, input int bad_pct);
    logic e;
    opcode_t o;
    for (int i = 0; i < n; i++) begin
      e = chance(en_pct);
      o = pick_op(kind);
      step(e, o, use_fwd, bad_pct);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      if (exp_edge.size() != 0 && exp_edge[0] == cycle) begin
        check_bit("res_valid", 1'b1, res_valid);
        check_word("res_word", exp_word[0], res_word);
        check_ret("ret_code", exp_ret[0], ret_code);
        check_bit("ret_en", |exp_ret[0], ret_en);
        void'(exp_edge.pop_front());
        void'(exp_word.pop_front());
        void'(exp_ret.pop_front());
      end else begin
        check_bit("res_valid", 1'b0, res_valid);
        check_word("res_word", '0, res_word);
        check_ret("ret_code", '0, ret_code);
        check_bit("ret_en", 1'b0, ret_en);
      end
    end
  end

  initial begin
    int wait_cnt;
    seed = 32'h3d99_1d63;
    cycle = 0;
    clk = 1'b0;
    rst = 1'b1;
    en = 1'b0;
    op = '0;
    opnd_a = '0;
    opnd_b = '0;
    bus_data = '0;
    fwd_now_a = '0;
    fwd_prev_a = '0;
    fwd_now_b = '0;
    fwd_prev_b = '0;
    last_bus = '0;
    repeat (10) step(1'b0, '0, 1'b0, 0);
    rst <= 1'b0;
    wait_cnt = 0;
    while (rst !== 1'b0) begin
      if (wait_cnt == WAIT_LIMIT) report_timeout("reset release");
      step(1'b0, '0, 1'b0, 0);
      wait_cnt++;
    end
    // idle outputs, then logic back to back and with gaps
    run_phase(20, 0, 0, 1'b0, 0);
    run_phase(40, 100, 0, 1'b0, 0);
    run_phase(150, 70, 0, 1'b0, 0);
    run_phase(150, 80, 1, 1'b0, 0);
    run_phase(300, 80, 2, 1'b1, 3);
    // parity faults and illegal opcodes
    run_phase(300, 80, 3, 1'b1, 25);
    wait_cnt = 0;
    while (exp_edge.size() != 0) begin
      if (wait_cnt == WAIT_LIMIT) report_timeout("outstanding results");
      step(1'b0, '0, 1'b0, 0);
      wait_cnt++;
    end
    repeat (5) step(1'b0, '0, 1'b0, 0);
    $display("** PASS **");
    $finish;
  end

endmodule
